// ==== Makefile ====
# Verilator build and run of the SRAM store testbench

TOP = tb_sram_bank_array
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f hdl/sram_defs.svh hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

# Pass only if the log holds the pass message
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module sram_bank_array

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+hdl
hdl/sram_pkg.sv
hdl/req_dispatch.sv
hdl/sram_bank.sv
hdl/rd_collect.sv
hdl/sram_bank_array.sv
tests/tb_sram_bank_array.sv

// ==== hdl/rd_collect.sv ====
/* Read return merge: picks the result of the bank that answered and lines up
   the out-of-range flag with the bank latency, giving one in-order result */

`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module rd_collect (
  input  logic                  CLK,
  input  logic                  rst,
  input  sram_pkg::bank_mask_t  bank_rd_valid,
  input  sram_pkg::word_t       rd_bdata0,
  input  sram_pkg::word_t       rd_bdata1,
  input  sram_pkg::word_t       rd_bdata2,
  input  logic                  rd_oob,
  output logic                  rd_valid,
  output sram_pkg::word_t       rd_data,
  output logic                  rd_err
);

  import sram_pkg::*;

  logic [`BANK_RD_LAT-1:0]  oob_pipe;  // Flag delay, same depth as a bank read
  logic                     oob_al;    // Flag aligned with bank results
  word_t                    sel0;
  word_t                    sel1;
  word_t                    sel2;

  // Shift the out-of-range flag along with the bank pipeline
  always_ff @(posedge CLK) begin
    if (rst) begin
      oob_pipe <= '0;
    end else begin
      oob_pipe <= {oob_pipe[`BANK_RD_LAT-2:0], rd_oob};
    end
  end

  assign oob_al = oob_pipe[`BANK_RD_LAT-1];

  // At most one bank answers per cycle
  assign sel0 = bank_rd_valid[0] ? rd_bdata0 : '0;
  assign sel1 = bank_rd_valid[1] ? rd_bdata1 : '0;
  assign sel2 = bank_rd_valid[2] ? rd_bdata2 : '0;

  assign rd_data  = sel0 | sel1 | sel2;  // Zero for an out-of-range read
  assign rd_valid = (|bank_rd_valid) | oob_al;
  assign rd_err   = oob_al;

endmodule

`default_nettype wire

// ==== hdl/req_dispatch.sv ====
/* Request front end: registers the write and read requests, decodes the bank
   and drives one-hot bank strobes, or error flags for the missing bank */

`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module req_dispatch (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  ready,
  input  logic                  wr_en,
  input  sram_pkg::mem_addr_t   wr_addr,
  input  sram_pkg::word_t       wr_data,
  input  sram_pkg::lane_en_t    wr_be,
  input  logic                  rd_en,
  input  sram_pkg::mem_addr_t   rd_addr,
  output sram_pkg::bank_mask_t  bank_wr,
  output sram_pkg::bank_addr_t  wr_baddr,
  output sram_pkg::word_t       wr_bdata,
  output sram_pkg::lane_en_t    wr_bbe,
  output sram_pkg::bank_mask_t  bank_rd,
  output sram_pkg::bank_addr_t  rd_baddr,
  output logic                  wr_err,
  output logic                  rd_oob
);

  import sram_pkg::*;

  logic                    wr_take;   // Write accepted this cycle
  logic                    rd_take;   // Read accepted this cycle
  logic [`BANK_SEL_W-1:0]  wr_sel;
  logic [`BANK_SEL_W-1:0]  rd_sel;
  logic                    wr_hit;    // Bank field names a real bank
  logic                    rd_hit;

  // One-hot bank select, all zero for a missing bank
  function automatic bank_mask_t bank_decode(input logic [`BANK_SEL_W-1:0] sel);
    bank_mask_t m;
    m = '0;
    if (sel < `NUM_BANKS) begin
      m[sel] = 1'b1;
    end
    return m;
  endfunction

  // Nothing is taken while the banks are still clearing
  assign wr_take = wr_en & ready;
  assign rd_take = rd_en & ready;

  assign wr_sel = wr_addr[`BANK_SEL_W+`BANK_AW-1:`BANK_AW];  // Upper field
  assign rd_sel = rd_addr[`BANK_SEL_W+`BANK_AW-1:`BANK_AW];
  assign wr_hit = (wr_sel < `NUM_BANKS);
  assign rd_hit = (rd_sel < `NUM_BANKS);

  // Strobes and flags, one cycle after the request
  always_ff @(posedge CLK) begin
    if (rst) begin
      bank_wr <= '0;
      bank_rd <= '0;
      wr_err  <= 1'b0;
      rd_oob  <= 1'b0;
    end else begin
      bank_wr <= wr_take ? bank_decode(wr_sel) : '0;
      bank_rd <= rd_take ? bank_decode(rd_sel) : '0;
      wr_err  <= wr_take & ~wr_hit;  // Write dropped, flag only
      rd_oob  <= rd_take & ~rd_hit;  // Collector answers zero later
    end
  end

  // Payload follows the strobes, shared by all banks
  always_ff @(posedge CLK) begin
    if (wr_take) begin
      wr_baddr <= wr_addr[`BANK_AW-1:0];
      wr_bdata <= wr_data;
      wr_bbe   <= wr_be;
    end
    if (rd_take) begin
      rd_baddr <= rd_addr[`BANK_AW-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sram_bank.sv ====
/* One SRAM bank with separate write and read ports
   Zero-fills itself after reset, then raises clr_done; reads take two cycles */

`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module sram_bank (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  wr,
  input  sram_pkg::bank_addr_t  wr_baddr,
  input  sram_pkg::word_t       wr_bdata,
  input  sram_pkg::lane_en_t    wr_bbe,
  input  logic                  rd,
  input  sram_pkg::bank_addr_t  rd_baddr,
  output logic                  clr_done,
  output logic                  bank_rd_valid,
  output sram_pkg::word_t       rd_bdata
);

  import sram_pkg::*;

  word_t       mem [`BANK_WORDS];  // Storage array

  clr_state_t  clr_state;
  bank_addr_t  clr_addr;           // Next word to zero
  logic        clr_last;           // Final word of the fill

  word_t       rd_q;               // Array read register
  logic        rd_v1;              // Valid for rd_q

  assign clr_last = (clr_addr == bank_addr_t'(`BANK_WORDS - 1));
  assign clr_done = (clr_state == CLR_IDLE);

  // Clear machine, one word per cycle
  always_ff @(posedge CLK) begin
    if (rst) begin
      clr_state <= CLR_RUN;
      clr_addr  <= '0;
    end else begin
      case (clr_state)
        CLR_RUN: begin
          clr_addr <= clr_addr + 1'b1;
          if (clr_last) begin
            clr_state <= CLR_IDLE;  // Whole bank now zero
          end
        end
        CLR_IDLE: begin
          clr_addr <= clr_addr;  // Parked until next reset
        end
        default: begin
          clr_state <= CLR_RUN;
        end
      endcase
    end
  end

  // Write port
  // Clear fill owns the port until done; requests are held off by ready
  always_ff @(posedge CLK) begin
    if (clr_state == CLR_RUN) begin
      mem[clr_addr] <= '0;
    end else if (wr) begin
      for (int l = 0; l < `LANES; l++) begin
        if (wr_bbe[l]) begin
          mem[wr_baddr][l*`LANE_W +: `LANE_W] <= wr_bdata[l*`LANE_W +: `LANE_W];
        end
      end
    end
  end

  // Read port, array register then output register
  // A write to the same word in the same cycle is not seen here
  always_ff @(posedge CLK) begin
    if (rd) begin
      rd_q <= mem[rd_baddr];
    end
    rd_bdata <= rd_q;
  end

  // Valid pipe matching the two data stages
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_v1         <= 1'b0;
      bank_rd_valid <= 1'b0;
    end else begin
      rd_v1         <= rd;
      bank_rd_valid <= rd_v1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sram_bank_array.sv ====
/* Top of the three-bank SRAM store
   Dispatcher feeds a generate loop of banks; collector returns reads after 3 cycles */

`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module sram_bank_array (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 wr_en,
  input  sram_pkg::mem_addr_t  wr_addr,
  input  sram_pkg::word_t      wr_data,
  input  sram_pkg::lane_en_t   wr_be,
  input  logic                 rd_en,
  input  sram_pkg::mem_addr_t  rd_addr,
  output logic                 ready,
  output logic                 rd_valid,
  output sram_pkg::word_t      rd_data,
  output logic                 rd_err,
  output logic                 wr_err
);

  import sram_pkg::*;

  bank_mask_t              bank_wr;        // Write strobe per bank
  bank_mask_t              bank_rd;        // Read strobe per bank
  bank_addr_t              wr_baddr;
  bank_addr_t              rd_baddr;
  word_t                   wr_bdata;
  lane_en_t                wr_bbe;
  logic                    rd_oob;         // Read of missing bank
  bank_mask_t              bank_rd_valid;
  word_t                   rd_bdata [`NUM_BANKS];
  logic [`NUM_BANKS-1:0]   clr_done;

  // Open for traffic once every bank is zeroed
  assign ready = &clr_done;

  req_dispatch i_req_dispatch (
    .CLK      (CLK),
    .rst      (rst),
    .ready    (ready),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_be    (wr_be),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .bank_wr  (bank_wr),
    .wr_baddr (wr_baddr),
    .wr_bdata (wr_bdata),
    .wr_bbe   (wr_bbe),
    .bank_rd  (bank_rd),
    .rd_baddr (rd_baddr),
    .wr_err   (wr_err),
    .rd_oob   (rd_oob)
  );

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    sram_bank i_sram_bank (
      .CLK           (CLK),
      .rst           (rst),
      .wr            (bank_wr[b]),
      .wr_baddr      (wr_baddr),
      .wr_bdata      (wr_bdata),
      .wr_bbe        (wr_bbe),
      .rd            (bank_rd[b]),
      .rd_baddr      (rd_baddr),
      .clr_done      (clr_done[b]),
      .bank_rd_valid (bank_rd_valid[b]),
      .rd_bdata      (rd_bdata[b])
    );
  end

  rd_collect i_rd_collect (
    .CLK           (CLK),
    .rst           (rst),
    .bank_rd_valid (bank_rd_valid),
    .rd_bdata0     (rd_bdata[0]),
    .rd_bdata1     (rd_bdata[1]),
    .rd_bdata2     (rd_bdata[2]),
    .rd_oob        (rd_oob),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .rd_err        (rd_err)
  );

endmodule

`default_nettype wire

// ==== hdl/sram_defs.svh ====
/* Sizing macros for the three-bank SRAM store
   Included by the package and by every module that needs a width or latency */

`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// Bank layout
`define NUM_BANKS   3      // Banks present, field value 3 is out of range
`define BANK_SEL_W  2      // Bank field at top of address
`define BANK_AW     10     // Word address inside a bank
`define BANK_WORDS  1024   // Words per bank, 2**BANK_AW

// Word and lane layout
`define DATA_W      36
`define LANES       4      // Byte lanes per word
`define LANE_W      9      // Bits per lane, 8 data plus parity slot

// Array read to output register, in cycles
`define BANK_RD_LAT 2

`endif

// ==== hdl/sram_pkg.sv ====
/* Shared types for the SRAM store
   Modules import this inside their body and use scoped names in port lists */

`default_nettype none

`include "sram_defs.svh"

package sram_pkg;

  typedef logic [`DATA_W-1:0]   word_t;       // One data word
  typedef logic [`LANES-1:0]    lane_en_t;    // Lane write enables, active high
  typedef logic [`BANK_AW-1:0]  bank_addr_t;  // Word address inside a bank
  typedef logic [`NUM_BANKS-1:0] bank_mask_t; // One strobe per bank

  // Bank select on top, bank_addr_t below
  typedef logic [`BANK_SEL_W+`BANK_AW-1:0] mem_addr_t;

  // Post-reset clear machine of a bank
  typedef enum logic {
    CLR_RUN,   // Zero-fill in progress
    CLR_IDLE   // Done, bank accepts traffic
  } clr_state_t;

endpackage

`default_nettype wire

// ==== tests/tb_sram_bank_array.sv ====
/* System testbench for the three-bank SRAM store
   Drives the request port, keeps a shadow copy of all banks and checks every
   read result, its latency and the error flags with assertions each cycle */

`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module tb_sram_bank_array;

  import sram_pkg::*;

  localparam int PERIOD    = 4;                  // ns
  localparam int CLR_CYC   = 1100;               // Bound on the post-reset clear
  localparam int PRE_CYC   = 20;                 // Requests sent while clearing
  localparam int SWEEP_CYC = 3 * `BANK_WORDS;    // Zero check of every word
  localparam int DIR_CYC   = 300;                // Directed phases together
  localparam int RAND_CYC  = 2000;
  localparam int MARGIN    = 500;
  localparam int WATCHDOG_CYC = CLR_CYC + PRE_CYC + SWEEP_CYC + DIR_CYC + RAND_CYC + MARGIN;

  // One expected read return
  typedef struct packed {
    logic [31:0] due;    // Cycle count at which rd_valid must be high
    word_t       data;
    logic        err;
  } rd_exp_t;

  logic       CLK;
  logic       rst;
  logic       wr_en;
  mem_addr_t  wr_addr;
  word_t      wr_data;
  lane_en_t   wr_be;
  logic       rd_en;
  mem_addr_t  rd_addr;
  logic       ready;
  logic       rd_valid;
  word_t      rd_data;
  logic       rd_err;
  logic       wr_err;

  integer       seed = 32'hf32172c9;
  logic [31:0]  cyc = '0;                  // Rising edges seen so far
  logic         checking = 1'b0;           // Set once reset is released
  word_t        shadow [3*`BANK_WORDS];    // Reference copy indexed by bank and word
  rd_exp_t      rd_q [$];                  // Reads in issue order
  logic [31:0]  werr_q [$];                // Due cycles of wr_err pulses
  rd_exp_t      head;
  logic         exp_rv;
  logic         exp_we;

  sram_bank_array i_sram_bank_array (
    .CLK      (CLK),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_be    (wr_be),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .ready    (ready),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_err   (rd_err),
    .wr_err   (wr_err)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD/2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 32'd1;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  // Watchdog sized from the phase lengths
  initial begin
    #(WATCHDOG_CYC * PERIOD);
    report_fail($sformatf("Timeout after %0d cycles, the test sequence did not finish",
                          WATCHDOG_CYC));
  end

  // Only enabled lanes take the new data
  function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                        input lane_en_t be);
    word_t w;
    w = old_w;
    for (int l = 0; l < `LANES; l++) begin
      if (be[l]) begin
        w[l*`LANE_W +: `LANE_W] = new_w[l*`LANE_W +: `LANE_W];
      end
    end
    return w;
  endfunction

  function automatic mem_addr_t mk_addr(input int bank, input int ba);
    mem_addr_t a;
    a = {bank[1:0], ba[`BANK_AW-1:0]};  // Bank field on top
    return a;
  endfunction

  function automatic logic [1:0] bank_of(input mem_addr_t a);
    return a[`BANK_SEL_W+`BANK_AW-1:`BANK_AW];
  endfunction

  function automatic word_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`DATA_W-1:0];
  endfunction

  // One request cycle starting 1 ns after a rising edge
  // Read is modelled before write so a same-cycle pair sees old data
  task automatic drive_cycle(input logic we, input mem_addr_t wa, input word_t wd,
                             input lane_en_t wbe, input logic re, input mem_addr_t ra);
    rd_exp_t e;
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    wr_be   = wbe;
    rd_en   = re;
    rd_addr = ra;
    if (ready) begin                      // Ignored by the DUT otherwise
      if (re) begin
        e.due = cyc + 32'd3;              // Fixed 3-cycle read latency
        if (bank_of(ra) == 2'd3) begin
          e.data = '0;
          e.err  = 1'b1;
        end else begin
          e.data = shadow[ra];
          e.err  = 1'b0;
        end
        rd_q.push_back(e);
      end
      if (we) begin
        if (bank_of(wa) == 2'd3) begin
          werr_q.push_back(cyc + 32'd1);  // Write dropped and flagged next cycle
        end else begin
          shadow[wa] = merge_lanes(shadow[wa], wd, wbe);
        end
      end
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
    end
  endtask

  task automatic write_word(input mem_addr_t a, input word_t d, input lane_en_t be);
    drive_cycle(1'b1, a, d, be, 1'b0, '0);
  endtask

  task automatic read_word(input mem_addr_t a);
    drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
  endtask

  // Idle until every expected result has shown up or 8 cycles pass
  task automatic wait_drain();
    int n;
    n = 0;
    while ((rd_q.size() != 0 || werr_q.size() != 0) && n < 8) begin
      idle_cycles(1);
      n++;
    end
  endtask

  // Outputs checked mid-cycle on the falling edge
  always @(negedge CLK) begin
    if (checking) begin
      exp_rv = (rd_q.size() != 0) && (rd_q[0].due == cyc);
      assert (rd_valid === exp_rv)
        else report_fail($sformatf("** Error: rd_valid expected 0x%h got 0x%h",
                                   exp_rv, rd_valid));
      if (exp_rv) begin
        head = rd_q.pop_front();
        assert (rd_data === head.data)
          else report_fail($sformatf("** Error: rd_data expected 0x%h got 0x%h",
                                     head.data, rd_data));
        assert (rd_err === head.err)
          else report_fail($sformatf("** Error: rd_err expected 0x%h got 0x%h",
                                     head.err, rd_err));
      end
      exp_we = (werr_q.size() != 0) && (werr_q[0] == cyc);
      assert (wr_err === exp_we)
        else report_fail($sformatf("** Error: wr_err expected 0x%h got 0x%h",
                                   exp_we, wr_err));
      if (exp_we) begin
        void'(werr_q.pop_front());
      end
    end
  end

  initial begin
    int          n;
    int          ba;
    mem_addr_t   a;
    logic [31:0] r;
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_be   = '0;
    rd_en   = 1'b0;
    rd_addr = '0;
    for (int i = 0; i < 3*`BANK_WORDS; i++) begin
      shadow[i] = '0;                     // Banks zero themselves after reset
    end
    repeat (2) @(posedge CLK);
    #1;
    rst      = 1'b0;
    checking = 1'b1;

    // Requests during the clear must be ignored
    assert (ready === 1'b0) else report_fail("ready was not low right after reset");
    for (int i = 0; i < PRE_CYC; i++) begin
      assert (ready === 1'b0) else report_fail("ready rose before the clear could finish");
      drive_cycle(1'b1, mk_addr(i % 4, i), rand_word(), 4'hf, 1'b1, mk_addr(i % 4, i));
    end
    n = 0;
    while (ready !== 1'b1 && n < CLR_CYC) begin
      idle_cycles(1);
      n++;
    end
    assert (ready === 1'b1) else report_fail("ready did not rise after the bank clear");
    // One cycle per word of a bank
    assert (PRE_CYC + n == `BANK_WORDS)
      else report_fail($sformatf("ready rose after %0d clear cycles instead of %0d",
                                 PRE_CYC + n, `BANK_WORDS));

    // Back-to-back reads of every word expect zero
    for (int i = 0; i < 3*`BANK_WORDS; i++) begin
      read_word(mk_addr(i / `BANK_WORDS, i % `BANK_WORDS));
    end
    wait_drain();

    // Full-lane write then read at both ends of each bank and at random words
    for (int b = 0; b < 3; b++) begin
      for (int k = 0; k < 4; k++) begin
        r  = $random(seed);
        ba = (k == 0) ? 0 : (k == 1) ? `BANK_WORDS - 1 : int'(r[`BANK_AW-1:0]);
        a  = mk_addr(b, ba);
        write_word(a, rand_word(), 4'hf);
        read_word(a);
      end
    end
    wait_drain();

    // Every lane mask with a read after each write
    for (int b = 0; b < 3; b++) begin
      a = mk_addr(b, 100 + b);
      write_word(a, rand_word(), 4'hf);
      for (int m = 0; m < 16; m++) begin
        write_word(a, rand_word(), lane_en_t'(m));
        read_word(a);
      end
    end
    wait_drain();

    // Same-cycle read and write followed by a read of the new word
    for (int b = 0; b < 3; b++) begin
      a = mk_addr(b, 200 + b);
      write_word(a, rand_word(), 4'hf);
      drive_cycle(1'b1, a, rand_word(), 4'hf, 1'b1, a);
      read_word(a);
    end
    wait_drain();

    // Missing bank 3 followed by the same word in the real banks
    a = mk_addr(3, 300);
    write_word(a, rand_word(), 4'hf);
    read_word(a);
    drive_cycle(1'b1, a, rand_word(), 4'hf, 1'b1, a);
    for (int b = 0; b < 3; b++) begin
      read_word(mk_addr(b, 300));
    end
    wait_drain();

    // Read every cycle with random writes in a small window so addresses clash
    for (int i = 0; i < RAND_CYC; i++) begin
      r = $random(seed);
      drive_cycle(r[0], mk_addr(int'(r[3:2]), int'(r[9:4])), rand_word(),
                  lane_en_t'(r[13:10]), 1'b1, mk_addr(int'(r[15:14]), int'(r[21:16])));
    end
    wait_drain();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
